/* src/snes_mem_pkg.sv */
// shared bus widths, types and map constants for the console memory request path
package snes_mem_pkg;

    // bus widths, fixed by the console core
    localparam int ROM_AW   = 24;  // full sdram byte address
    localparam int WRAM_AW  = 17;  // 128 KB work ram
    localparam int BSRAM_AW = 20;  // battery-backed save ram
    localparam int ARAM_AW  = 16;  // 64 KB audio ram
    localparam int BYTE_W   = 8;
    localparam int WORD_W   = 16;  // sdram data width

    typedef logic [ROM_AW-1:0]   rom_addr_t;
    typedef logic [WRAM_AW-1:0]  wram_addr_t;
    typedef logic [BSRAM_AW-1:0] bsram_addr_t;
    typedef logic [ARAM_AW-1:0]  aram_addr_t;
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [WORD_W-1:0]   word_t;

    // byte lanes of one sdram word
    // bit 1 selects the high byte, bit 0 the low byte
    typedef logic [1:0] lane_t;

    // wram sits at banks EE-EF of the sdram map
    // 7 prefix bits + 17 wram bits = 24 bit address
    localparam logic [ROM_AW-WRAM_AW-1:0] WRAM_BANK_PREFIX = 7'b1110_111;

    // map mode C carts read bsram without the read strobe
    localparam logic [3:0] MAP_NIBBLE_NO_RD = 4'hC;

endpackage

/* src/run_ctrl.sv */
// core run enable and enable-qualified F/R phase strobes, one instance in the memory top
module run_ctrl (
    input  logic wclk,
    input  logic resetn,
    input  logic sdram_busy,   // sdram still initializing or refreshing
    input  logic loader_fail,  // cartridge load went wrong
    input  logic frame_pause,  // video asks the core to hold for frame sync
    input  logic sysclkf_ce,   // core F phase
    input  logic sysclkr_ce,   // core R phase
    output logic enable,       // to core
    output logic f_phase,      // registered F strobe, slot timing
    output logic r_phase       // registered R strobe, slot timing
);

    logic run_ok;  // all hold conditions clear

    // core only runs once memory is usable and no pause is pending
    assign run_ok = ~sdram_busy & ~loader_fail & ~frame_pause;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
        end else begin
            enable <= run_ok;  // one cycle behind the conditions
        end
    end

    // phases only count while the core is actually running
    // these pulses open every sdram slot downstream
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            f_phase <= 1'b0;
            r_phase <= 1'b0;
        end else begin
            f_phase <= sysclkf_ce & enable;  // reads happen here
            r_phase <= sysclkr_ce & enable;  // writes happen here
        end
    end

endmodule

/* src/sdram_req_gen.sv */
// arbitrates loader, ROM and WRAM onto the sdram cpu port and registers the bsram request
module sdram_req_gen (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      f_phase,
    input  logic                      r_phase,
    // rom bus from core
    input  snes_mem_pkg::rom_addr_t   rom_addr,
    input  logic                      rom_ce_n,
    // wram bus from core
    input  snes_mem_pkg::wram_addr_t  wram_addr,
    input  snes_mem_pkg::byte_t       wram_d,
    input  logic                      wram_ce_n,
    input  logic                      wram_rd_n,
    input  logic                      wram_we_n,
    // bsram bus from core
    input  snes_mem_pkg::bsram_addr_t bsram_addr,
    input  snes_mem_pkg::byte_t       bsram_d,
    input  logic                      bsram_ce_n,
    input  logic                      bsram_rd_n,
    input  logic                      bsram_we_n,
    input  snes_mem_pkg::byte_t       rom_type,     // map control byte
    // cartridge loader stream
    input  logic                      loading,
    input  snes_mem_pkg::byte_t       loader_byte,
    input  logic                      loader_valid,
    // cpu port toward sdram
    output snes_mem_pkg::rom_addr_t   cpu_addr,
    output snes_mem_pkg::word_t       cpu_din,
    output snes_mem_pkg::lane_t       cpu_ds,
    output logic                      cpu_port,     // 0 rom/loader, 1 wram
    output logic                      cpu_rd,
    output logic                      cpu_wr,
    // bsram port toward sdram
    output snes_mem_pkg::bsram_addr_t bsram_addr_q,
    output snes_mem_pkg::byte_t       bsram_din_q,
    output logic                      bsram_rd,
    output logic                      bsram_wr
);

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_LOADER,
        SRC_ROM,
        SRC_WRAM
    } req_src_e;

    req_src_e                src;          // winner this cycle
    snes_mem_pkg::rom_addr_t loader_addr;  // next loader write address
    logic                    loading_q;    // for rising edge of loading
    logic                    wram_rd;
    logic                    wram_wr;
    logic                    bsram_map_rd; // map mode forces reads

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // fixed priority, loader beats rom beats wram
    always_comb begin
        if (loading && loader_valid) begin
            src = SRC_LOADER;
        end else if (!rom_ce_n && f_phase) begin
            src = SRC_ROM;  // rom only on F slots
        end else if (wram_rd || wram_wr) begin
            src = SRC_WRAM; // phase check happens below
        end else begin
            src = SRC_NONE;
        end
    end

    // one request per cycle, all zero when idle
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_addr <= '0;
            cpu_din  <= '0;
            cpu_ds   <= '0;
            cpu_port <= 1'b0;
            cpu_rd   <= 1'b0;
            cpu_wr   <= 1'b0;
        end else begin
            cpu_addr <= '0;
            cpu_din  <= '0;
            cpu_ds   <= '0;
            cpu_port <= 1'b0;
            cpu_rd   <= 1'b0;
            cpu_wr   <= 1'b0;
            case (src)
                SRC_LOADER: begin
                    cpu_addr <= loader_addr;
                    cpu_din  <= {loader_byte, loader_byte};     // byte on both halves
                    cpu_ds   <= {loader_addr[0], ~loader_addr[0]}; // odd -> high lane
                    cpu_wr   <= 1'b1;
                end
                SRC_ROM: begin
                    cpu_addr <= rom_addr;
                    cpu_ds   <= 2'b11;  // full word, core picks the byte
                    cpu_rd   <= 1'b1;
                end
                SRC_WRAM: begin
                    // banks EE-EF, 128 KB
                    cpu_addr <= {snes_mem_pkg::WRAM_BANK_PREFIX, wram_addr};
                    cpu_din  <= {wram_d, wram_d};
                    cpu_ds   <= {wram_addr[0], ~wram_addr[0]};
                    cpu_port <= 1'b1;
                    cpu_rd   <= wram_rd & f_phase;  // read on F
                    cpu_wr   <= wram_wr & r_phase;  // write on R
                end
                default: begin
                end
            endcase
        end
    end

    // loader address counter
    // restart at zero when a new load begins
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_q   <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_q <= loading;
            if (loading && !loading_q) begin
                loader_addr <= '0;  // clear wins over a byte
            end else if (loader_valid) begin
                loader_addr <= loader_addr + 1'b1;
            end
        end
    end

    // bsram strobes, registered once like the cpu port
    assign bsram_map_rd = (rom_type[7:4] == snes_mem_pkg::MAP_NIBBLE_NO_RD);

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bsram_rd <= 1'b0;
            bsram_wr <= 1'b0;
        end else begin
            bsram_rd <= ~bsram_ce_n & (~bsram_rd_n | bsram_map_rd) & f_phase;
            bsram_wr <= ~bsram_ce_n & ~bsram_we_n & r_phase;
        end
    end

    always_ff @(posedge wclk) begin
        bsram_addr_q <= bsram_addr;  // follows the strobes by one cycle
        bsram_din_q  <= bsram_d;
    end

endmodule

/* src/lane_steer.sv */
// picks the right byte of each returned sdram word for the ROM, WRAM and ARAM read buses
module lane_steer (
    input  logic                     wclk,
    input  logic                     resetn,
    input  snes_mem_pkg::word_t      cpu_port0,  // rom/loader port data
    input  snes_mem_pkg::word_t      cpu_port1,  // wram port data
    input  logic                     rom_addr0,
    input  logic                     rom_word,   // core wants a 16-bit rom read
    input  logic                     wram_addr0,
    input  snes_mem_pkg::word_t      aram_dout,
    input  snes_mem_pkg::aram_addr_t aram_addr,
    input  logic                     aram_ce_n,
    input  logic                     aram_oe_n,
    input  logic                     aram_we_n,
    output snes_mem_pkg::word_t      rom_q,
    output snes_mem_pkg::byte_t      wram_q,
    output snes_mem_pkg::byte_t      aram_q,
    output logic                     aram_rd,
    output logic                     aram_wr
);

    logic aram_lsb;  // byte select of the last aram read

    // word reads and even byte reads take the word as is
    // odd byte reads want the high byte on the low half
    assign rom_q = (rom_word || !rom_addr0) ? cpu_port0
                                            : {cpu_port0[7:0], cpu_port0[15:8]};

    assign wram_q = wram_addr0 ? cpu_port1[15:8] : cpu_port1[7:0];  // odd -> high

    // aram strobes straight to sdram
    assign aram_rd = ~aram_ce_n & ~aram_oe_n;
    assign aram_wr = ~aram_ce_n & ~aram_we_n;

    // data comes back after the strobe, so hold the select
    // from the read cycle until the next read
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            aram_lsb <= 1'b0;
        end else if (aram_rd) begin
            aram_lsb <= aram_addr[0];
        end
    end

    assign aram_q = aram_lsb ? aram_dout[15:8] : aram_dout[7:0];

endmodule

/* src/snes_mem_top.sv */
// memory request top level between the console core, cartridge loader and one sdram controller
module snes_mem_top (
    input  logic                      wclk,
    input  logic                      resetn,
    // control
    input  logic                      sdram_busy,
    input  logic                      loader_fail,
    input  logic                      frame_pause,
    // core timing
    input  logic                      sysclkf_ce,
    input  logic                      sysclkr_ce,
    output logic                      enable,
    input  snes_mem_pkg::byte_t       rom_type,
    // core rom bus
    input  snes_mem_pkg::rom_addr_t   rom_addr,
    input  logic                      rom_ce_n,
    input  logic                      rom_word,
    output snes_mem_pkg::word_t       rom_q,
    // core wram bus
    input  snes_mem_pkg::wram_addr_t  wram_addr,
    input  snes_mem_pkg::byte_t       wram_d,
    input  logic                      wram_ce_n,
    input  logic                      wram_rd_n,
    input  logic                      wram_we_n,
    output snes_mem_pkg::byte_t       wram_q,
    // core bsram bus
    input  snes_mem_pkg::bsram_addr_t bsram_addr,
    input  snes_mem_pkg::byte_t       bsram_d,
    input  logic                      bsram_ce_n,
    input  logic                      bsram_rd_n,
    input  logic                      bsram_we_n,
    // core aram bus
    input  snes_mem_pkg::aram_addr_t  aram_addr,
    input  snes_mem_pkg::byte_t       aram_d,
    input  logic                      aram_ce_n,
    input  logic                      aram_oe_n,
    input  logic                      aram_we_n,
    output snes_mem_pkg::byte_t       aram_q,
    // loader stream
    input  logic                      loading,
    input  snes_mem_pkg::byte_t       loader_byte,
    input  logic                      loader_valid,
    // sdram cpu port
    output snes_mem_pkg::rom_addr_t   cpu_addr,
    output snes_mem_pkg::word_t       cpu_din,
    output snes_mem_pkg::lane_t       cpu_ds,
    output logic                      cpu_port,
    output logic                      cpu_rd,
    output logic                      cpu_wr,
    input  snes_mem_pkg::word_t       cpu_port0,
    input  snes_mem_pkg::word_t       cpu_port1,
    // sdram bsram port
    output snes_mem_pkg::bsram_addr_t bsram_addr_q,
    output snes_mem_pkg::byte_t       bsram_din_q,
    output logic                      bsram_rd,
    output logic                      bsram_wr,
    // sdram aram port, address goes to sdram from the core directly
    input  snes_mem_pkg::word_t       aram_dout,
    output snes_mem_pkg::word_t       aram_din,
    output logic                      aram_rd,
    output logic                      aram_wr
);

    logic f_phase;  // slot strobes
    logic r_phase;

    // 8-bit aram writes, byte on both halves
    assign aram_din = {aram_d, aram_d};

    run_ctrl u_run_ctrl (
        .wclk        (wclk),
        .resetn      (resetn),
        .sdram_busy  (sdram_busy),
        .loader_fail (loader_fail),
        .frame_pause (frame_pause),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .enable      (enable),
        .f_phase     (f_phase),
        .r_phase     (r_phase)
    );

    sdram_req_gen u_sdram_req_gen (
        .wclk         (wclk),
        .resetn       (resetn),
        .f_phase      (f_phase),
        .r_phase      (r_phase),
        .rom_addr     (rom_addr),
        .rom_ce_n     (rom_ce_n),
        .wram_addr    (wram_addr),
        .wram_d       (wram_d),
        .wram_ce_n    (wram_ce_n),
        .wram_rd_n    (wram_rd_n),
        .wram_we_n    (wram_we_n),
        .bsram_addr   (bsram_addr),
        .bsram_d      (bsram_d),
        .bsram_ce_n   (bsram_ce_n),
        .bsram_rd_n   (bsram_rd_n),
        .bsram_we_n   (bsram_we_n),
        .rom_type     (rom_type),
        .loading      (loading),
        .loader_byte  (loader_byte),
        .loader_valid (loader_valid),
        .cpu_addr     (cpu_addr),
        .cpu_din      (cpu_din),
        .cpu_ds       (cpu_ds),
        .cpu_port     (cpu_port),
        .cpu_rd       (cpu_rd),
        .cpu_wr       (cpu_wr),
        .bsram_addr_q (bsram_addr_q),
        .bsram_din_q  (bsram_din_q),
        .bsram_rd     (bsram_rd),
        .bsram_wr     (bsram_wr)
    );

    lane_steer u_lane_steer (
        .wclk       (wclk),
        .resetn     (resetn),
        .cpu_port0  (cpu_port0),
        .cpu_port1  (cpu_port1),
        .rom_addr0  (rom_addr[0]),
        .rom_word   (rom_word),
        .wram_addr0 (wram_addr[0]),
        .aram_dout  (aram_dout),
        .aram_addr  (aram_addr),
        .aram_ce_n  (aram_ce_n),
        .aram_oe_n  (aram_oe_n),
        .aram_we_n  (aram_we_n),
        .rom_q      (rom_q),
        .wram_q     (wram_q),
        .aram_q     (aram_q),
        .aram_rd    (aram_rd),
        .aram_wr    (aram_wr)
    );

endmodule

/* sim/tb_snes_mem_top.sv */
// trace-driven testbench for snes_mem_top that reads sim/snes_mem_trace.txt from the project root
module tb_snes_mem_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SLOT_TIMEOUT = 20;  // cycles before a strobe counts as lost
    // strobe selectors
    localparam int SEL_CPU_RD = 0;
    localparam int SEL_CPU_WR = 1;
    localparam int SEL_BS_RD  = 2;
    localparam int SEL_BS_WR  = 3;

    logic        wclk, resetn;
    logic        sdram_busy, loader_fail, frame_pause;
    logic        sysclkf_ce, sysclkr_ce, enable;
    logic [7:0]  rom_type;
    logic [23:0] rom_addr;
    logic        rom_ce_n, rom_word;
    logic [15:0] rom_q;
    logic [16:0] wram_addr;
    logic [7:0]  wram_d, wram_q;
    logic        wram_ce_n, wram_rd_n, wram_we_n;
    logic [19:0] bsram_addr, bsram_addr_q;
    logic [7:0]  bsram_d, bsram_din_q;
    logic        bsram_ce_n, bsram_rd_n, bsram_we_n, bsram_rd, bsram_wr;
    logic [15:0] aram_addr;
    logic [7:0]  aram_d, aram_q;
    logic        aram_ce_n, aram_oe_n, aram_we_n, aram_rd, aram_wr;
    logic [15:0] aram_dout, aram_din;
    logic        loading, loader_valid;
    logic [7:0]  loader_byte;
    logic [23:0] cpu_addr;
    logic [15:0] cpu_din, cpu_port0, cpu_port1;
    logic [1:0]  cpu_ds;
    logic        cpu_port, cpu_rd, cpu_wr;

    int          errors;
    int          timeouts;
    logic        en_prev;  // enable value before the last hold change
    logic [31:0] lfsr;

    snes_mem_top u_dut (.*);

    always #5 wclk = ~wclk;  // 10 ns period

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // galois form with taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        int i;
        for (i = 0; i < 8; i++) begin
            b[i] = lfsr[0];  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        rand_byte = b;
    endfunction

    function automatic logic strobe(input int sel);
        case (sel)
            SEL_CPU_RD: strobe = cpu_rd;
            SEL_CPU_WR: strobe = cpu_wr;
            SEL_BS_RD:  strobe = bsram_rd;
            default:    strobe = bsram_wr;
        endcase
    endfunction

    // one core phase pulse and then the strobe two cycles on or silence
    task automatic phase_slot(input logic f, input int sel, input logic want);
        int n;
        @(posedge wclk);
        if (f) begin
            sysclkf_ce <= 1'b1;
        end else begin
            sysclkr_ce <= 1'b1;
        end
        @(posedge wclk);
        sysclkf_ce <= 1'b0;
        sysclkr_ce <= 1'b0;
        if (want) begin
            n = 0;
            do begin
                @(negedge wclk);
                n++;
            end while (!strobe(sel) && n < SLOT_TIMEOUT);
            if (!strobe(sel)) begin
                timeouts++;
                $display("timeout: strobe %0d never showed up after the phase pulse", sel);
            end else begin
                check_eq(n, 2, "slot latency");  // phase reg + request reg
            end
        end else begin
            repeat (4) begin
                @(negedge wclk);
                check_eq(strobe(sel), 1'b0, "strobe on wrong phase");
            end
        end
    endtask

    task automatic set_hold(input logic [31:0] data, input logic [31:0] expv);
        @(posedge wclk);
        frame_pause <= data[2];
        loader_fail <= data[1];
        sdram_busy  <= data[0];
        @(negedge wclk);
        check_eq(enable, en_prev, "enable before its cycle");
        @(negedge wclk);
        check_eq(enable, expv[0], "enable");
        en_prev = expv[0];
        if (!expv[0]) begin  // a stopped core gets no slots
            @(posedge wclk);
            rom_ce_n  <= 1'b0;
            wram_ce_n <= 1'b0;
            wram_we_n <= 1'b0;
            phase_slot(1'b1, SEL_CPU_RD, 1'b0);
            phase_slot(1'b0, SEL_CPU_WR, 1'b0);
            @(posedge wclk);
            rom_ce_n  <= 1'b1;
            wram_ce_n <= 1'b1;
            wram_we_n <= 1'b1;
        end
    endtask

    // rom strobe stays active the whole time and the loader has to win
    task automatic stream_loader(input int count);
        logic [7:0] q[$];
        logic [7:0] b;
        int j;
        // stray byte with loading low writes nothing but bumps the counter
        @(posedge wclk);
        loader_valid <= 1'b1;
        @(posedge wclk);
        loader_valid <= 1'b0;
        loading      <= 1'b1;
        rom_addr     <= 24'h00_8000;
        rom_ce_n     <= 1'b0;
        sysclkf_ce   <= 1'b1;
        @(negedge wclk);
        check_eq(cpu_wr, 1'b0, "loader write without loading");
        for (j = 0; j <= count; j++) begin
            @(posedge wclk);
            if (j < count) begin
                b = rand_byte();
                q.push_back(b);
                loader_byte  <= b;
                loader_valid <= 1'b1;
            end else begin
                loader_valid <= 1'b0;
                loading      <= 1'b0;
                rom_ce_n     <= 1'b1;
                sysclkf_ce   <= 1'b0;
            end
            @(negedge wclk);
            check_eq(cpu_rd, 1'b0, "rom read during load");
            if (j > 0) begin  // byte j-1 lands now
                b = q.pop_front();
                check_eq(cpu_wr, 1'b1, "loader write pulse");
                check_eq(cpu_addr, j - 1, "loader address");
                check_eq(cpu_din, {b, b}, "loader data");
                check_eq(cpu_ds, ((j - 1) % 2) ? 2'b10 : 2'b01, "loader lanes");
            end
        end
    endtask

    task automatic read_rom(input logic [31:0] addr, data, arg, expv);
        @(posedge wclk);
        rom_addr  <= addr[23:0];
        rom_ce_n  <= 1'b0;
        rom_word  <= arg[0];
        cpu_port0 <= data[15:0];
        phase_slot(1'b0, SEL_CPU_RD, 1'b0);  // R phase never reads rom
        phase_slot(1'b1, SEL_CPU_RD, 1'b1);
        check_eq(cpu_addr, addr[23:0], "rom address");
        check_eq(cpu_ds, 2'b11, "rom lanes");
        check_eq(cpu_port, 1'b0, "rom port");
        check_eq(rom_q, expv[15:0], "rom_q");
        @(negedge wclk);
        check_eq(cpu_rd, 1'b0, "second rom read");
        @(posedge wclk);
        rom_ce_n <= 1'b1;
    endtask

    // arg 0 read on F, arg 1 write on R
    task automatic access_wram(input logic [31:0] addr, data, arg, expv);
        logic [23:0] full;
        int sel;
        full = 24'hEE_0000 | addr[16:0];  // banks EE-EF
        sel  = arg[0] ? SEL_CPU_WR : SEL_CPU_RD;
        @(posedge wclk);
        wram_addr <= addr[16:0];
        wram_d    <= data[7:0];
        cpu_port1 <= data[15:0];
        wram_ce_n <= 1'b0;
        wram_rd_n <= arg[0];
        wram_we_n <= ~arg[0];
        phase_slot(arg[0], sel, 1'b0);
        // request shape is there without a phase
        check_eq(cpu_addr, full, "wram idle address");
        check_eq(cpu_port, 1'b1, "wram idle port");
        phase_slot(~arg[0], sel, 1'b1);
        check_eq(cpu_addr, full, "wram address");
        check_eq(cpu_port, 1'b1, "wram port");
        check_eq(cpu_ds, addr[0] ? 2'b10 : 2'b01, "wram lanes");
        if (arg[0]) begin
            check_eq(cpu_din, expv[15:0], "wram write data");
            check_eq(cpu_rd, 1'b0, "read during wram write");
        end else begin
            check_eq(wram_q, expv[7:0], "wram_q");
            check_eq(cpu_wr, 1'b0, "write during wram read");
        end
        @(posedge wclk);
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
        wram_we_n <= 1'b1;
    endtask

    // data high byte is rom_type, arg is {ce_n, rd_n, we_n}, expv is {rd, wr}
    task automatic access_bsram(input logic [31:0] addr, data, arg, expv);
        @(posedge wclk);
        bsram_addr <= addr[19:0];
        bsram_d    <= data[7:0];
        rom_type   <= data[15:8];
        bsram_ce_n <= arg[2];
        bsram_rd_n <= arg[1];
        bsram_we_n <= arg[0];
        phase_slot(1'b1, SEL_BS_RD, expv[1]);
        if (expv[1]) begin
            check_eq(bsram_addr_q, addr[19:0], "bsram address");
            check_eq(bsram_din_q, data[7:0], "bsram data");
        end
        phase_slot(1'b0, SEL_BS_WR, expv[0]);
        @(posedge wclk);
        bsram_ce_n <= 1'b1;
        bsram_rd_n <= 1'b1;
        bsram_we_n <= 1'b1;
        rom_type   <= 8'h00;
    endtask

    // arg is {ce_n, oe_n, we_n}, expv is {rd, wr, aram_q}
    task automatic access_aram(input logic [31:0] addr, data, arg, expv);
        @(posedge wclk);
        aram_addr <= addr[15:0];
        aram_dout <= data[15:0];
        aram_d    <= data[7:0];
        aram_ce_n <= arg[2];
        aram_oe_n <= arg[1];
        aram_we_n <= arg[0];
        @(negedge wclk);
        check_eq(aram_rd, expv[9], "aram_rd");  // same cycle
        check_eq(aram_wr, expv[8], "aram_wr");
        check_eq(aram_din, {data[7:0], data[7:0]}, "aram_din");
        @(posedge wclk);
        aram_ce_n <= 1'b1;
        aram_oe_n <= 1'b1;
        aram_we_n <= 1'b1;
        @(negedge wclk);
        check_eq(aram_q, expv[7:0], "aram_q");  // from the latched select
    endtask

    initial begin
        int          fd;
        int          got;
        string       line;
        logic [31:0] kind, addr, data, arg, expv;
        errors = 0;
        timeouts = 0;
        lfsr = 32'h8324_c5da;
        wclk = 1'b0;
        resetn = 1'b0;
        sdram_busy = 1'b0;  // only reset keeps the core stopped
        loader_fail = 1'b0;
        frame_pause = 1'b0;
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
        rom_type = 8'h00;
        rom_addr = '0;
        rom_ce_n = 1'b1;
        rom_word = 1'b0;
        wram_addr = '0;
        wram_d = '0;
        wram_ce_n = 1'b1;
        wram_rd_n = 1'b1;
        wram_we_n = 1'b1;
        bsram_addr = '0;
        bsram_d = '0;
        bsram_ce_n = 1'b1;
        bsram_rd_n = 1'b1;
        bsram_we_n = 1'b1;
        aram_addr = '0;
        aram_d = '0;
        aram_ce_n = 1'b1;
        aram_oe_n = 1'b1;
        aram_we_n = 1'b1;
        aram_dout = '0;
        loading = 1'b0;
        loader_byte = '0;
        loader_valid = 1'b0;
        cpu_port0 = '0;
        cpu_port1 = '0;
        repeat (4) @(posedge wclk);
        resetn <= 1'b1;
        @(negedge wclk);
        check_eq(enable, 1'b0, "enable right after reset");
        @(negedge wclk);
        check_eq(enable, 1'b1, "enable one cycle after reset");
        en_prev = 1'b1;
        fd = $fopen("sim/snes_mem_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file sim/snes_mem_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                got = $sscanf(line, "%h %h %h %h %h", kind, addr, data, arg, expv);
                if (line.len() > 0 && line[0] != "#" && got == 5) begin
                    case (kind)
                        0: set_hold(data, expv);
                        1: stream_loader(arg);
                        2: read_rom(addr, data, arg, expv);
                        3: access_wram(addr, data, arg, expv);
                        4: access_bsram(addr, data, arg, expv);
                        5: access_aram(addr, data, arg, expv);
                        default: begin
                            errors++;
                            $display("unknown step kind %0h in the trace", kind);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge wclk);
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim/snes_mem_trace.txt */
# kind addr data arg expect, all hex, kinds 0 hold 1 loader 2 rom 3 wram 4 bsram 5 aram
# 0 data={pause,fail,busy} 1 arg=bytes 3 arg=write 4/5 arg={ce_n,rd_n|oe_n,we_n}
0 0 1 0 0
0 0 0 0 1
0 0 4 0 0
0 0 0 0 1
0 0 2 0 0
0 0 0 0 1
1 0 0 9 0
2 123457 a1b2 0 b2a1
2 123457 a1b2 1 a1b2
2 00fff0 c3d4 0 c3d4
3 00011 5a3c 0 5a
3 1fffe 5a3c 0 3c
3 00203 0097 1 9797
4 12345 2066 1 2
4 12346 2077 2 1
4 12347 c088 3 2
4 12348 2099 3 0
4 12349 c0aa 4 0
5 0101 beef 1 2be
5 0202 1234 2 112
5 0202 1234 1 234
5 0303 5678 7 078

/* snes_mem_top.f */
src/snes_mem_pkg.sv
src/run_ctrl.sv
src/sdram_req_gen.sv
src/lane_steer.sv
src/snes_mem_top.sv
sim/tb_snes_mem_top.sv

/* Bender.yml */
package:
  name: snes_mem_top

sources:
  - src/snes_mem_pkg.sv
  - src/run_ctrl.sv
  - src/sdram_req_gen.sv
  - src/lane_steer.sv
  - src/snes_mem_top.sv
  - target: simulation
    files:
      - sim/tb_snes_mem_top.sv
